//--- led_ctrl_top.f
+incdir+hdl
hdl/led_ctrl_pkg.sv
hdl/led_cmd_if.sv
hdl/prm_rom.sv
hdl/prm_checker.sv
hdl/led_channel.sv
hdl/prm_reply.sv
hdl/led_ctrl_top.sv
verification/led_ctrl_tb.sv

//--- verification/led_ctrl_tb.sv
module led_ctrl_tb;
  import led_ctrl_pkg::*;

  localparam int N_LEDS         = 2;
  localparam int CLKS_PER_MS    = 4;
  localparam int PERIOD_MAX     = 1000;
  localparam int BRIGHT_MAX     = 100;
  localparam int PWM_FRAME      = 100;
  localparam int BLINK_PERIOD   = 3;
  localparam int RUN_LIMIT      = 100;
  localparam int TIMEOUT_CYCLES = 20000;

  logic              clk = 1'b0;
  logic              arst_n;
  logic              req_stb;
  logic              req_write;
  logic [ADDR_W-1:0] req_addr;
  logic [DATA_W-1:0] req_data;
  logic              rsp_stb;
  logic              rsp_err;
  logic [DATA_W-1:0] rsp_data;
  logic [N_LEDS-1:0] leds;

  integer            seed = 23;
  int                cycle_cnt = 0;
  string             test_name = "none";
  logic [N_LEDS-1:0] lit_model; // Expected status bits

  led_ctrl_top #(.PRM_COUNT(10), .N_LEDS(N_LEDS), .CLKS_PER_MS(CLKS_PER_MS)) i_dut (
    .clk, .arst_n, .req_stb, .req_write, .req_addr, .req_data,
    .rsp_stb, .rsp_err, .rsp_data, .leds
  );

  always #10 clk = ~clk;

  task automatic stop_with_error(input string why);
    $display("Verification failed");
    $fatal(1, "%s", why);
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_with_error($sformatf("Timeout after %0d cycles in test %s", cycle_cnt, test_name));
    end
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_error($sformatf("CHECK FAILED %s %s expected %0d actual %0d",
                                test_name, what, expected, actual));
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the response
  task automatic send_request(input logic write, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, output logic err,
                              output logic [DATA_W-1:0] rdata);
    req_stb   = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_data  = data;
    @(negedge clk);
    req_stb   = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_data  = '0;
    if (rsp_stb !== 1'b0) stop_with_error("Response strobe came one cycle after the request");
    @(negedge clk);
    if (rsp_stb !== 1'b1) stop_with_error("Response strobe missing two cycles after the request");
    err   = rsp_err;
    rdata = rsp_data;
    @(negedge clk);
    if (rsp_stb !== 1'b0) stop_with_error("Response strobe stayed high for more than one cycle");
  endtask

  task automatic write_prm(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic exp_err);
    logic              err;
    logic [DATA_W-1:0] rdata;
    send_request(1'b1, addr, data, err, rdata);
    check_value($sformatf("write error flag at %0d", addr), exp_err, err);
    if (exp_err) begin
      check_value($sformatf("write data on error at %0d", addr), 0, rdata);
    end
  endtask

  task automatic read_prm(input logic [ADDR_W-1:0] addr, input logic exp_err,
                          input logic [DATA_W-1:0] exp_data);
    logic              err;
    logic [DATA_W-1:0] rdata;
    send_request(1'b0, addr, '0, err, rdata);
    check_value($sformatf("read error flag at %0d", addr), exp_err, err);
    check_value($sformatf("read data at %0d", addr), exp_data, rdata);
  endtask

  task automatic check_leds_steady(input logic [N_LEDS-1:0] expected, input int cycles);
    repeat (cycles) begin
      check_value("leds", expected, leds);
      @(negedge clk);
    end
  endtask

  // Counts falling edges until the LED pattern changes
  task automatic measure_run(output int len);
    logic [N_LEDS-1:0] start;
    start = leds;
    len   = 0;
    while (leds == start && len < RUN_LIMIT) begin
      @(negedge clk);
      len++;
    end
  endtask

  task automatic test_reset_values();
    test_name = "reset_values";
    check_value("leds", 0, leds);
    read_prm(ADDR_LED_PERIOD, 1'b0, 16'd500);
    read_prm(ADDR_LED_BRIGHTNESS, 1'b0, 16'd100);
    read_prm(ADDR_STATUS, 1'b0, 16'd0);
    check_leds_steady('0, PWM_FRAME);
  endtask

  task automatic test_range_checks();
    logic [DATA_W-1:0] period;
    logic [DATA_W-1:0] bright;
    test_name = "range_checks";
    repeat (8) begin
      period = DATA_W'($unsigned($random(seed)) % (PERIOD_MAX + 1));
      bright = DATA_W'($unsigned($random(seed)) % (BRIGHT_MAX + 1));
      write_prm(ADDR_LED_PERIOD, period, 1'b0);
      write_prm(ADDR_LED_BRIGHTNESS, bright, 1'b0);
      read_prm(ADDR_LED_PERIOD, 1'b0, period);
      read_prm(ADDR_LED_BRIGHTNESS, 1'b0, bright);
    end
    write_prm(ADDR_LED_PERIOD, DATA_W'(PERIOD_MAX + 1), 1'b1);
    write_prm(ADDR_LED_PERIOD, 16'hffff, 1'b1);
    write_prm(ADDR_LED_BRIGHTNESS, DATA_W'(BRIGHT_MAX + 1), 1'b1);
    read_prm(ADDR_LED_PERIOD, 1'b0, period); // Rejected writes leave the old value
    read_prm(ADDR_LED_BRIGHTNESS, 1'b0, bright);
  endtask

  task automatic test_addr_rights();
    test_name = "addr_rights";
    for (int a = 10; a < 16; a++) begin
      read_prm(ADDR_W'(a), 1'b1, 16'd0);
      write_prm(ADDR_W'(a), 16'd0, 1'b1);
    end
    write_prm(ADDR_STATUS, 16'd0, 1'b1);
    for (int a = ADDR_BLINK_ON; a <= ADDR_1_OFF; a++) begin
      read_prm(ADDR_W'(a), 1'b0, 16'd0);
    end
  endtask

  task automatic run_command(input logic [ADDR_W-1:0] addr, input logic [N_LEDS-1:0] mask,
                             input logic turn_on);
    write_prm(addr, 16'd1, 1'b0);
    lit_model = turn_on ? (lit_model | mask) : (lit_model & ~mask);
    read_prm(ADDR_STATUS, 1'b0, DATA_W'(lit_model));
    check_leds_steady(lit_model, PWM_FRAME); // Full brightness keeps a lit LED high
  endtask

  task automatic test_commands();
    test_name = "commands";
    lit_model = '0;
    write_prm(ADDR_LED_BRIGHTNESS, 16'd100, 1'b0);
    write_prm(ADDR_ALL_ON, 16'd0, 1'b0);
    read_prm(ADDR_STATUS, 1'b0, 16'd0);
    run_command(ADDR_ALL_ON, 2'b11, 1'b1);
    run_command(ADDR_0_OFF, 2'b01, 1'b0);
    run_command(ADDR_1_OFF, 2'b10, 1'b0);
    run_command(ADDR_0_ON, 2'b01, 1'b1);
    run_command(ADDR_1_ON, 2'b10, 1'b1);
    run_command(ADDR_ALL_OFF, 2'b11, 1'b0);
  endtask

  task automatic test_brightness();
    logic [N_LEDS-1:0] samples [2*PWM_FRAME];
    int                high_cnt;
    test_name = "brightness";
    write_prm(ADDR_LED_BRIGHTNESS, 16'd37, 1'b0);
    write_prm(ADDR_ALL_ON, 16'd1, 1'b0);
    for (int i = 0; i < 2 * PWM_FRAME; i++) begin
      samples[i] = leds;
      @(negedge clk);
    end
    for (int n = 0; n < N_LEDS; n++) begin
      for (int s = 0; s <= PWM_FRAME; s++) begin
        high_cnt = 0;
        for (int i = s; i < s + PWM_FRAME; i++) begin
          high_cnt += samples[i][n];
        end
        check_value($sformatf("high cycles of led %0d from sample %0d", n, s), 37, high_cnt);
      end
    end
    write_prm(ADDR_ALL_OFF, 16'd1, 1'b0);
  endtask

  task automatic test_blink();
    logic [N_LEDS-1:0] level;
    logic [N_LEDS-1:0] next_level;
    int                len;
    test_name = "blink";
    write_prm(ADDR_LED_PERIOD, DATA_W'(BLINK_PERIOD), 1'b0);
    write_prm(ADDR_LED_BRIGHTNESS, 16'd100, 1'b0);
    write_prm(ADDR_BLINK_ON, 16'd1, 1'b0);
    read_prm(ADDR_STATUS, 1'b0, 16'd3);
    measure_run(len);
    if (len >= RUN_LIMIT) stop_with_error("LEDs never toggled after the blink command");
    level = leds;
    check_value("level after first toggle", 0, level);
    repeat (4) begin
      measure_run(len);
      check_value("blink run length", BLINK_PERIOD * CLKS_PER_MS, len);
      next_level = ~level;
      check_value("blink level", next_level, leds);
      level = leds;
    end
  endtask

  initial begin
    arst_n    = 1'b0;
    req_stb   = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_data  = '0;
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    test_reset_values();
    test_range_checks();
    test_addr_rights();
    test_commands();
    test_brightness();
    test_blink();
    $display("Verification passed");
    $finish;
  end

endmodule

//--- hdl/led_ctrl_top.sv
module led_ctrl_top #(
  parameter int PRM_COUNT   = 10,
  parameter int N_LEDS      = 2,
  parameter int CLKS_PER_MS = 50000
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            req_stb,
  input  logic                            req_write,
  input  logic [led_ctrl_pkg::ADDR_W-1:0] req_addr,
  input  logic [led_ctrl_pkg::DATA_W-1:0] req_data,
  output logic                            rsp_stb,
  output logic                            rsp_err,
  output logic [led_ctrl_pkg::DATA_W-1:0] rsp_data,
  output logic [N_LEDS-1:0]               leds
);
  import led_ctrl_pkg::*;

  prm_entry_t        entry;
  led_mode_t         modes [N_LEDS];
  logic              done_stb;
  logic              done_err;
  logic [ADDR_W-1:0] done_addr;

  led_cmd_if #(.N_LEDS(N_LEDS)) cmd_bus ();

  // Request address goes straight to the ROM
  prm_rom #(.PRM_COUNT(PRM_COUNT)) i_rom (.clk, .addr(req_addr), .entry);

  prm_checker #(.PRM_COUNT(PRM_COUNT)) i_checker (
    .clk, .arst_n, .req_stb, .req_write, .req_addr, .req_data, .entry,
    .cmd_bus(cmd_bus.src), .done_stb, .done_err, .done_addr
  );

  for (genvar i = 0; i < N_LEDS; i++) begin : g_led
    led_channel #(.CLKS_PER_MS(CLKS_PER_MS)) i_channel (
      .clk, .arst_n, .cmd_bus(cmd_bus.snk), .index(i), .mode(modes[i]), .led(leds[i])
    );
  end

  prm_reply #(.N_LEDS(N_LEDS)) i_reply (
    .clk, .arst_n, .done_stb, .done_err, .done_addr, .cmd_bus(cmd_bus.mon), .modes,
    .rsp_stb, .rsp_err, .rsp_data
  );

endmodule

//--- hdl/prm_reply.sv
module prm_reply #(
  parameter int N_LEDS = 2
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            done_stb,
  input  logic                            done_err,
  input  logic [led_ctrl_pkg::ADDR_W-1:0] done_addr,
  led_cmd_if.mon                          cmd_bus,
  input  led_ctrl_pkg::led_mode_t         modes [N_LEDS],
  output logic                            rsp_stb,
  output logic                            rsp_err,
  output logic [led_ctrl_pkg::DATA_W-1:0] rsp_data
);
  import led_ctrl_pkg::*;

  logic [N_LEDS-1:0] lit;
  logic [DATA_W-1:0] rd_data;

  always_comb begin
    for (int i = 0; i < N_LEDS; i++) begin
      lit[i] = modes[i] != mode_off; // Blinking counts as lit
    end
  end

  // Command entries and rejected requests read as zero
  always_comb begin
    rd_data = '0;
    if (!done_err) begin
      case (done_addr)
        ADDR_LED_PERIOD:     rd_data = cmd_bus.period;
        ADDR_LED_BRIGHTNESS: rd_data = cmd_bus.brightness;
        ADDR_STATUS:         rd_data = DATA_W'(lit);
        default:             rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_stb <= 1'b0;
    end else begin
      rsp_stb <= done_stb;
    end
  end

  always_ff @(posedge clk) begin
    if (done_stb) begin
      rsp_err  <= done_err;
      rsp_data <= rd_data;
    end
  end

endmodule

//--- hdl/led_channel.sv
module led_channel #(
  parameter int CLKS_PER_MS = 50000
) (
  input  logic                    clk,
  input  logic                    arst_n,
  led_cmd_if.snk                  cmd_bus,
  input  int unsigned             index,
  output led_ctrl_pkg::led_mode_t mode,
  output logic                    led
);
  import led_ctrl_pkg::*;

  localparam int PWM_W = $clog2(PWM_STEPS);
  localparam int MS_W  = $clog2(CLKS_PER_MS + 1);

  logic              hit;
  logic [PWM_W-1:0]  pwm_cnt;
  logic              duty;
  logic [MS_W-1:0]   ms_cnt;
  logic [DATA_W-1:0] tick_cnt; // Whole ms within the current blink phase
  logic              phase;

  assign hit = cmd_bus.cmd_stb && cmd_bus.cmd_mask[index];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mode <= mode_off;
    end else if (hit) begin
      case (cmd_bus.cmd)
        cmd_on:    mode <= mode_on;
        cmd_blink: mode <= mode_blink;
        default:   mode <= mode_off;
      endcase
    end
  end

  // Free running PWM frame
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pwm_cnt <= '0;
    end else if (pwm_cnt == PWM_W'(PWM_STEPS - 1)) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
    end
  end

  assign duty = DATA_W'(pwm_cnt) < cmd_bus.brightness;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ms_cnt   <= '0;
      tick_cnt <= '0;
      phase    <= 1'b1;
    end else if ((hit && cmd_bus.cmd == cmd_blink) || cmd_bus.period == '0) begin
      ms_cnt   <= '0; // Blink always starts lit
      tick_cnt <= '0;
      phase    <= 1'b1;
    end else if (mode == mode_blink) begin
      if (ms_cnt == MS_W'(CLKS_PER_MS - 1)) begin
        ms_cnt <= '0;
        // Compare with >= so a shorter period written mid-phase still ends it
        if (tick_cnt >= cmd_bus.period - 1'b1) begin
          tick_cnt <= '0;
          phase    <= ~phase;
        end else begin
          tick_cnt <= tick_cnt + 1'b1;
        end
      end else begin
        ms_cnt <= ms_cnt + 1'b1;
      end
    end
  end

  assign led = (mode == mode_on && duty) || (mode == mode_blink && duty && phase);

endmodule

//--- hdl/prm_checker.sv
module prm_checker #(
  parameter int PRM_COUNT = 10
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            req_stb,
  input  logic                            req_write,
  input  logic [led_ctrl_pkg::ADDR_W-1:0] req_addr,
  input  logic [led_ctrl_pkg::DATA_W-1:0] req_data,
  input  led_ctrl_pkg::prm_entry_t        entry,
  led_cmd_if.src                          cmd_bus,
  output logic                            done_stb,
  output logic                            done_err,
  output logic [led_ctrl_pkg::ADDR_W-1:0] done_addr
);
  import led_ctrl_pkg::*;

  logic              pend_stb;
  logic              pend_write;
  logic [ADDR_W-1:0] pend_addr;
  logic [DATA_W-1:0] pend_data;
  logic [DATA_W-1:0] period_q;
  logic [DATA_W-1:0] bright_q;
  logic              addr_bad;
  logic              rights_bad;
  logic              range_bad;
  logic              wr_ok;

  // The ROM looks up the descriptor while the request waits here
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_stb <= 1'b0;
    end else begin
      pend_stb <= req_stb;
    end
  end

  always_ff @(posedge clk) begin
    if (req_stb) begin
      pend_write <= req_write;
      pend_addr  <= req_addr;
      pend_data  <= req_data;
    end
  end

  assign addr_bad   = pend_addr >= PRM_COUNT;
  assign rights_bad = pend_write ? (entry.rights == ro) : (entry.rights == wo);
  assign range_bad  = pend_write && (pend_data < entry.min || pend_data > entry.max);

  assign done_stb  = pend_stb;
  assign done_err  = addr_bad || rights_bad || range_bad;
  assign done_addr = pend_addr;
  assign wr_ok     = pend_stb && pend_write && !done_err;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      period_q <= PERIOD_RESET;
      bright_q <= BRIGHT_RESET;
    end else if (wr_ok && !entry.is_exe) begin
      if (pend_addr == ADDR_LED_PERIOD) period_q <= pend_data;
      if (pend_addr == ADDR_LED_BRIGHTNESS) bright_q <= pend_data;
    end
  end

  assign cmd_bus.period     = period_q;
  assign cmd_bus.brightness = bright_q;
  assign cmd_bus.cmd_stb    = wr_ok && entry.is_exe && pend_data[0]; // Range limits it to 0 or 1

  always_comb begin
    cmd_bus.cmd      = cmd_off;
    cmd_bus.cmd_mask = '0;
    case (pend_addr)
      ADDR_BLINK_ON: begin
        cmd_bus.cmd      = cmd_blink;
        cmd_bus.cmd_mask = '1;
      end
      ADDR_ALL_ON: begin
        cmd_bus.cmd      = cmd_on;
        cmd_bus.cmd_mask = '1;
      end
      ADDR_ALL_OFF: cmd_bus.cmd_mask = '1;
      ADDR_0_ON: begin
        cmd_bus.cmd         = cmd_on;
        cmd_bus.cmd_mask[0] = 1'b1;
      end
      ADDR_0_OFF: cmd_bus.cmd_mask[0] = 1'b1;
      ADDR_1_ON: begin
        cmd_bus.cmd         = cmd_on;
        cmd_bus.cmd_mask[1] = 1'b1;
      end
      ADDR_1_OFF: cmd_bus.cmd_mask[1] = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- hdl/prm_rom.sv
module prm_rom #(
  parameter int PRM_COUNT = 10
) (
  input  logic                            clk,
  input  logic [led_ctrl_pkg::ADDR_W-1:0] addr,
  output led_ctrl_pkg::prm_entry_t        entry
);
  import led_ctrl_pkg::*;

  prm_entry_t rom [PRM_COUNT];

  initial begin
    rom[ADDR_LED_PERIOD] = '{prm: "period", min: 16'd0, max: 16'd1000,
                             units: "ms", rights: rw, is_exe: 1'b0};

    rom[ADDR_LED_BRIGHTNESS] = '{prm: "bright", min: 16'd0, max: 16'd100,
                                 units: "unit", rights: rw, is_exe: 1'b0};

    rom[ADDR_BLINK_ON] = '{prm: "blink_on", min: 16'd0, max: 16'd1,
                           units: "", rights: rw, is_exe: 1'b1};

    rom[ADDR_ALL_ON] = '{prm: "all_on", min: 16'd0, max: 16'd1,
                         units: "", rights: rw, is_exe: 1'b1};

    rom[ADDR_ALL_OFF] = '{prm: "all_off", min: 16'd0, max: 16'd1,
                          units: "", rights: rw, is_exe: 1'b1};

    rom[ADDR_0_ON] = '{prm: "led0_on", min: 16'd0, max: 16'd1,
                       units: "", rights: rw, is_exe: 1'b1};

    rom[ADDR_0_OFF] = '{prm: "led0_off", min: 16'd0, max: 16'd1,
                        units: "", rights: rw, is_exe: 1'b1};

    rom[ADDR_1_ON] = '{prm: "led1_on", min: 16'd0, max: 16'd1,
                       units: "", rights: rw, is_exe: 1'b1};

    rom[ADDR_1_OFF] = '{prm: "led1_off", min: 16'd0, max: 16'd1,
                        units: "", rights: rw, is_exe: 1'b1};

    // Lamp state bits, one per channel
    rom[ADDR_STATUS] = '{prm: "status", min: 16'd0, max: 16'd3,
                         units: "", rights: ro, is_exe: 1'b0};
  end

  // Unknown parameter numbers read as an empty descriptor
  always_ff @(posedge clk) begin
    if (addr < PRM_COUNT) begin
      entry <= rom[addr];
    end else begin
      entry <= '0;
    end
  end

endmodule

//--- hdl/led_cmd_if.sv
interface led_cmd_if #(
  parameter int N_LEDS = 2
);
  import led_ctrl_pkg::*;

  logic [DATA_W-1:0] period;
  logic [DATA_W-1:0] brightness;
  logic              cmd_stb;
  led_cmd_t          cmd;
  logic [N_LEDS-1:0] cmd_mask; // One bit per channel

  modport src (output period, output brightness, output cmd_stb, output cmd, output cmd_mask);

  modport snk (input period, input brightness, input cmd_stb, input cmd, input cmd_mask);

  // Register readback only
  modport mon (input period, input brightness);

endinterface

//--- hdl/led_ctrl_pkg.sv
package led_ctrl_pkg;

  localparam int DATA_W = 16;
  localparam int ADDR_W = 4;

  localparam logic [DATA_W-1:0] PERIOD_RESET = 16'd500; // Blink half period in ms
  localparam logic [DATA_W-1:0] BRIGHT_RESET = 16'd100;

  // Clocks in one PWM frame, brightness counts in these steps
  localparam int PWM_STEPS = 100;

  `include "led_reg_addrs.svh"

  typedef enum logic [1:0] {
    ro = 2'd0,
    wo = 2'd1,
    rw = 2'd2
  } prm_rights_t;

  // One descriptor per parameter
  typedef struct packed {
    logic [63:0]      prm;    // Name, 8 characters
    logic [15:0]      min;
    logic [15:0]      max;
    logic [31:0]      units;  // 4 characters
    prm_rights_t      rights;
    logic             is_exe; // Writing 1 runs a command
  } prm_entry_t;

  typedef enum logic [1:0] {
    mode_off   = 2'd0,
    mode_on    = 2'd1,
    mode_blink = 2'd2
  } led_mode_t;

  typedef enum logic [1:0] {
    cmd_on    = 2'd0,
    cmd_off   = 2'd1,
    cmd_blink = 2'd2
  } led_cmd_t;

endpackage

//--- hdl/led_reg_addrs.svh
`ifndef LED_REG_ADDRS_SVH
`define LED_REG_ADDRS_SVH

// Parameter numbers as seen by the host

// Settings
localparam logic [ADDR_W-1:0] ADDR_LED_PERIOD     = 4'd0;
localparam logic [ADDR_W-1:0] ADDR_LED_BRIGHTNESS = 4'd1;

// Commands, a write of 1 fires them
localparam logic [ADDR_W-1:0] ADDR_BLINK_ON       = 4'd2;
localparam logic [ADDR_W-1:0] ADDR_ALL_ON         = 4'd3;
localparam logic [ADDR_W-1:0] ADDR_ALL_OFF        = 4'd4;
localparam logic [ADDR_W-1:0] ADDR_0_ON           = 4'd5;
localparam logic [ADDR_W-1:0] ADDR_0_OFF          = 4'd6;
localparam logic [ADDR_W-1:0] ADDR_1_ON           = 4'd7;
localparam logic [ADDR_W-1:0] ADDR_1_OFF          = 4'd8;

localparam logic [ADDR_W-1:0] ADDR_STATUS         = 4'd9; // Lamp states, read only

`endif
